//--- all.f
+incdir+hw
hw/etx_pkg.sv
hw/emesh_decode.sv
hw/etx_framer.sv
hw/etx_serializer.sv
hw/etx_wait_sync.sv
hw/etx_io.sv
tb/etx_checker.sv
tb/tb_etx_io.sv

//--- hw/emesh_decode.sv
`timescale 1ns/1ps
`include "etx_settings.svh"

module emesh_decode
(
   input  logic                   tx_lclk_io,
   input  logic                   tx_access,
   input  logic [`ETX_PW-1:0]     tx_packet,
   output etx_pkg::emesh_fields_t fields
);

   import etx_pkg::*;

   // Captured fabric packet
   logic [`ETX_PW-1:0] packet_reg;

   // ########################################################################
   // Packet capture
   // ########################################################################

   // Held for the whole frame, next access only in IDLE
   always_ff @(posedge tx_lclk_io)
   begin
      if (tx_access)
      begin
         packet_reg <= tx_packet;
      end
   end

   // ########################################################################
   // Field split
   // ########################################################################

   // Bit 7 is a spare slot in the packet
   always_comb
   begin
      fields.write    = packet_reg[0];
      fields.datamode = datamode_e'(packet_reg[2:1]);
      fields.ctrlmode = packet_reg[6:3];
      fields.dstaddr  = packet_reg[39:8];
      fields.data     = packet_reg[71:40];
      fields.srcaddr  = packet_reg[103:72];
   end

endmodule

//--- hw/etx_framer.sv
`timescale 1ns/1ps

module etx_framer
(
   input  logic               tx_lclk_io,
   input  logic               nreset,
   input  logic               tx_access,
   input  logic               tx_burst,
   output etx_pkg::tx_state_e state,
   output etx_pkg::tx_state_e state_d,
   output logic               tx_frame,
   output logic               tx_io_ack
);

   import etx_pkg::*;

   // ########################################################################
   // Transmit state machine
   // ########################################################################

   // Free running once started
   always_ff @(posedge tx_lclk_io)
   begin
      if (!nreset)
      begin
         state <= IDLE;
      end
      else
      begin
         case (state)
            IDLE    : state <= tx_access ? CYCLE1 : IDLE;
            CYCLE1  : state <= CYCLE2;
            CYCLE2  : state <= CYCLE3;
            CYCLE3  : state <= CYCLE4;
            CYCLE4  : state <= CYCLE5;
            CYCLE5  : state <= CYCLE6;
            CYCLE6  : state <= CYCLE7;
            // Burst repeats the data beat
            CYCLE7  : state <= tx_burst ? CYCLE4 : IDLE;
            default : state <= IDLE;
         endcase
      end
   end

   // ########################################################################
   // Frame level and acknowledge
   // ########################################################################

   // Delayed state drives the lane select
   // Frame one stage later, aligned with lane word
   always_ff @(posedge tx_lclk_io)
   begin
      if (!nreset)
      begin
         state_d  <= IDLE;
         tx_frame <= 1'b0;
      end
      else
      begin
         state_d  <= state;
         tx_frame <= |state_d;
      end
   end

   // Wide ack, set in CYCLE4, cleared back in IDLE
   always_ff @(posedge tx_lclk_io)
   begin
      if (!nreset)
      begin
         tx_io_ack <= 1'b0;
      end
      else if (state == CYCLE4)
      begin
         tx_io_ack <= 1'b1;
      end
      else if (state == IDLE)
      begin
         tx_io_ack <= 1'b0;
      end
   end

endmodule

//--- hw/etx_io.sv
`timescale 1ns/1ps
`include "etx_settings.svh"

module etx_io
(
   input  logic                tx_lclk_io,
   input  logic                nreset,
   input  logic [`ETX_PW-1:0]  tx_packet,
   input  logic                tx_access,
   input  logic                tx_burst,
   input  etx_pkg::wait_pair_t txi_wait,
   output etx_pkg::lane_word_t tx_lane,
   output logic                tx_frame,
   output logic                tx_io_ack,
   output etx_pkg::wait_pair_t tx_wait
);

   import etx_pkg::*;

   // Decoded packet toward the serializer
   emesh_fields_t fields;

   // Sequencer state, current and one cycle late
   tx_state_e     state;
   tx_state_e     state_d;

   // ########################################################################
   // Decode
   // ########################################################################

   emesh_decode u_decode (
      .tx_lclk_io (tx_lclk_io),
      .tx_access  (tx_access),
      .tx_packet  (tx_packet),
      .fields     (fields)
   );

   // ########################################################################
   // Framer and serializer
   // ########################################################################

   etx_framer u_framer (
      .tx_lclk_io (tx_lclk_io),
      .nreset     (nreset),
      .tx_access  (tx_access),
      .tx_burst   (tx_burst),
      .state      (state),
      .state_d    (state_d),
      .tx_frame   (tx_frame),
      .tx_io_ack  (tx_io_ack)
   );

   etx_serializer u_serializer (
      .tx_lclk_io (tx_lclk_io),
      .nreset     (nreset),
      .state      (state),
      .state_d    (state_d),
      .fields     (fields),
      .tx_lane    (tx_lane)
   );

   // Pushback back to the fabric, report only
   etx_wait_sync u_wait_sync (
      .tx_lclk_io (tx_lclk_io),
      .nreset     (nreset),
      .txi_wait   (txi_wait),
      .tx_wait    (tx_wait)
   );

endmodule

//--- hw/etx_pkg.sv
`include "etx_settings.svh"

package etx_pkg;

   // Transfer size of one mesh access
   typedef enum logic [1:0] {
      DM_BYTE   = 2'd0,
      DM_HALF   = 2'd1,
      DM_WORD   = 2'd2,
      DM_DOUBLE = 2'd3
   } datamode_e;

   // Decoded mesh packet
   typedef struct packed {
      logic               write;
      datamode_e          datamode;
      logic [3:0]         ctrlmode;
      logic [`ETX_AW-1:0] dstaddr;
      logic [`ETX_AW-1:0] data;
      logic [`ETX_AW-1:0] srcaddr;
   } emesh_fields_t;

   // Transmit sequence, seven cycles per frame
   typedef enum logic [2:0] {
      IDLE   = 3'd0,
      CYCLE1 = 3'd1,
      CYCLE2 = 3'd2,
      CYCLE3 = 3'd3,
      CYCLE4 = 3'd4,
      CYCLE5 = 3'd5,
      CYCLE6 = 3'd6,
      CYCLE7 = 3'd7
   } tx_state_e;

   // Pin data for one transmit cycle
   typedef logic [`ETX_LW-1:0] lane_word_t;

   // Pushback pair from the receiver
   typedef struct packed {
      logic wr;
      logic rd;
   } wait_pair_t;

endpackage

//--- hw/etx_serializer.sv
`timescale 1ns/1ps
`include "etx_settings.svh"

module etx_serializer
(
   input  logic                   tx_lclk_io,
   input  logic                   nreset,
   input  etx_pkg::tx_state_e     state,
   input  etx_pkg::tx_state_e     state_d,
   input  etx_pkg::emesh_fields_t fields,
   output etx_pkg::lane_word_t    tx_lane
);

   import etx_pkg::*;

   // Transmit double, header then data/src
   logic [2*`ETX_AW-1:0] tx_double;

   // ########################################################################
   // Double load
   // ########################################################################

   // Header in CYCLE1, data and srcaddr in CYCLE4
   // Header layout, low 48 bits used
   //    ~write, 7 zeros, ctrlmode, dstaddr, datamode, write, valid
   always_ff @(posedge tx_lclk_io)
   begin
      if (state == CYCLE1)
      begin
         tx_double <= {16'b0, ~fields.write, 7'b0, fields.ctrlmode,
                       fields.dstaddr, fields.datamode, fields.write, 1'b1};
      end
      else if (state == CYCLE4)
      begin
         tx_double <= {fields.data, fields.srcaddr};
      end
   end

   // ########################################################################
   // Lane word select
   // ########################################################################

   // One 16-bit slice per cycle, high half first
   always_ff @(posedge tx_lclk_io)
   begin
      if (!nreset)
      begin
         tx_lane <= '0;
      end
      else
      begin
         case (state_d)
            // Header words
            CYCLE1  : tx_lane <= tx_double[47:32];
            CYCLE2  : tx_lane <= tx_double[31:16];
            CYCLE3  : tx_lane <= tx_double[15:0];
            // Data hi/lo, then srcaddr hi/lo
            CYCLE4  : tx_lane <= tx_double[63:48];
            CYCLE5  : tx_lane <= tx_double[47:32];
            CYCLE6  : tx_lane <= tx_double[31:16];
            CYCLE7  : tx_lane <= tx_double[15:0];
            // Quiet lane between frames
            default : tx_lane <= '0;
         endcase
      end
   end

endmodule

//--- hw/etx_settings.svh
`ifndef ETX_SETTINGS_SVH
`define ETX_SETTINGS_SVH

// ##########################################################################
// Link widths
// ##########################################################################

// Fabric packet, one access
`define ETX_PW 104

// Mesh address and data word
`define ETX_AW 32

// Lane word, rising half in the high byte
`define ETX_LW 16

`endif

//--- hw/etx_wait_sync.sv
`timescale 1ns/1ps

module etx_wait_sync
(
   input  logic                tx_lclk_io,
   input  logic                nreset,
   input  etx_pkg::wait_pair_t txi_wait,
   output etx_pkg::wait_pair_t tx_wait
);

   import etx_pkg::*;

   // First stage, may go metastable
   wait_pair_t wait_meta;

   // Pushback comes from the receiver clock domain
   always_ff @(posedge tx_lclk_io)
   begin
      if (!nreset)
      begin
         wait_meta <= '0;
         tx_wait   <= '0;
      end
      else
      begin
         wait_meta <= txi_wait;
         // Settled copy for the fabric
         tx_wait   <= wait_meta;
      end
   end

endmodule

//--- run.sh
#!/bin/sh
# Build the etx_io testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timescale 1ns/1ps --top-module tb_etx_io -f all.f -o sim_etx \
   > sim.log 2>&1 \
   && ./obj_dir/sim_etx >> sim.log 2>&1 \
   || echo "TEST FAILED" >> sim.log
cat sim.log
! grep -q "TEST FAILED" sim.log

//--- tb/etx_checker.sv
`timescale 1ns/1ps

module etx_checker
(
   input  logic                tx_lclk_io,
   input  logic                nreset,
   input  logic                tx_access,
   input  etx_pkg::lane_word_t tx_lane,
   input  logic                tx_frame,
   input  logic                tx_io_ack,
   input  etx_pkg::wait_pair_t txi_wait,
   input  etx_pkg::wait_pair_t tx_wait,
   output int                  lane_errs,
   output int                  frame_errs,
   output int                  ack_errs,
   output int                  wait_errs,
   output int                  other_errs
);

   import etx_pkg::*;

   // Expected lane stream and frame lengths, filled by the testbench
   lane_word_t exp_words[$];
   int         exp_lens[$];

   // Position in the current frame, in edges after T0
   bit active;
   int beat;
   int frame_len;

   // Pin wait bits one and two edges back
   wait_pair_t wait_d1;
   wait_pair_t wait_d2;

   task automatic queue_word(input lane_word_t word);
      exp_words.push_back(word);
   endtask

   task automatic add_frame(input int len);
      exp_lens.push_back(len);
   endtask

   function automatic int words_left();
      return exp_words.size();
   endfunction

   task automatic show_mismatch(input string name, input logic [15:0] expv,
                                input logic [15:0] actv);
      $display("FAIL %0t %s expected %0h actual %0h", $time, name, expv, actv);
   endtask

   // ########################################################################
   // Compare on the rising edge, values from the edge before
   // ########################################################################

   always @(posedge tx_lclk_io)
   begin
      logic       exp_frame;
      logic       exp_ack;
      lane_word_t exp_lane;
      if (!nreset)
      begin
         active  = 1'b0;
         beat    = 0;
         wait_d1 = '0;
         wait_d2 = '0;
      end
      else
      begin
         // Frame after edges T2 to T(len+1)
         exp_frame = active && beat >= 2 && beat <= frame_len + 1;
         // Ack from T4 until one edge after the return to IDLE
         exp_ack   = active && beat >= 4 && beat <= frame_len;
         exp_lane  = '0;
         if (exp_frame)
         begin
            if (exp_words.size() == 0)
            begin
               other_errs++;
               $display("Error at %0t: frame cycle with no expected lane word", $time);
            end
            else
               exp_lane = exp_words.pop_front();
         end
         if (tx_frame !== exp_frame)
         begin
            frame_errs++;
            show_mismatch("tx_frame", {15'b0, exp_frame}, {15'b0, tx_frame});
         end
         if (tx_io_ack !== exp_ack)
         begin
            ack_errs++;
            show_mismatch("tx_io_ack", {15'b0, exp_ack}, {15'b0, tx_io_ack});
         end
         // Quiet lane outside a frame
         if (tx_lane !== exp_lane)
         begin
            lane_errs++;
            show_mismatch("tx_lane", exp_lane, tx_lane);
         end
         // Two flops between pin and fabric
         if (tx_wait !== wait_d2)
         begin
            wait_errs++;
            show_mismatch("tx_wait", {14'b0, wait_d2}, {14'b0, tx_wait});
         end
         wait_d2 = wait_d1;
         wait_d1 = txi_wait;
         if (active)
         begin
            beat++;
            if (beat > frame_len + 2)
               active = 1'b0;
         end
         // T0 of a new packet
         if (tx_access === 1'b1)
         begin
            if (exp_lens.size() == 0)
            begin
               other_errs++;
               $display("Error at %0t: access with no expected frame queued", $time);
            end
            else
            begin
               frame_len = exp_lens.pop_front();
               beat      = 0;
               active    = 1'b1;
            end
         end
      end
   end

endmodule

//--- tb/etx_stimulus.txt
# write datamode ctrlmode dstaddr data srcaddr bursts wait_wr wait_rd, then lane words 0 to 6
# lane words: header hi, mid, lo, data hi, lo, srcaddr hi, lo (all hex)
1 2 0 80000000 12345678 00000000 0 0 0 0008 0000 000b 1234 5678 0000 0000
0 3 5 9abcdef0 0badcafe 80800124 0 1 0 8059 abcd ef0d 0bad cafe 8080 0124
1 0 f 00000001 deadbeef a5a55a5a 0 0 1 00f0 0000 0013 dead beef a5a5 5a5a
1 1 3 12345678 cafef00d 0000ffff 1 1 1 0031 2345 6787 cafe f00d 0000 ffff
0 0 0 fffffffc 00000000 13579bdf 0 0 0 800f ffff ffc1 0000 0000 1357 9bdf
0 1 a 40000ab0 55aa33cc 11112222 2 1 0 80a4 0000 ab05 55aa 33cc 1111 2222
1 3 7 0e0f1011 89abcdef fedcba98 0 1 1 0070 e0f1 011f 89ab cdef fedc ba98
0 2 c 2468ace0 ffffffff 00010002 1 0 1 80c2 468a ce09 ffff ffff 0001 0002
1 2 1 7fffffff 00000001 80000000 0 0 0 0017 ffff fffb 0000 0001 8000 0000
0 0 9 c0ffee00 a0b0c0d0 01234567 3 1 1 809c 0ffe e001 a0b0 c0d0 0123 4567
1 1 6 00000000 76543210 fedcba98 0 1 0 0060 0000 0007 7654 3210 fedc ba98
0 3 e 5a5a5a5a 3c3c3c3c c3c3c3c3 0 0 0 80e5 a5a5 a5ad 3c3c 3c3c c3c3 c3c3

//--- tb/tb_etx_io.sv
`timescale 1ns/1ps
`include "etx_settings.svh"

module tb_etx_io;

   import etx_pkg::*;

   // Cycles allowed for any single wait
   localparam int WAIT_LIMIT = 200;

   logic               tx_lclk_io;
   logic               nreset;
   logic [`ETX_PW-1:0] tx_packet;
   logic               tx_access;
   logic               tx_burst;
   wait_pair_t         txi_wait;
   lane_word_t         tx_lane;
   logic               tx_frame;
   logic               tx_io_ack;
   wait_pair_t         tx_wait;

   // Checker counts, then timeouts and file trouble seen here
   int lane_errs;
   int frame_errs;
   int ack_errs;
   int wait_errs;
   int other_errs;
   int run_errs;
   bit timed_out;

   // 20 ns link clock
   initial
   begin
      tx_lclk_io = 1'b0;
      forever
      begin
         #10 tx_lclk_io = ~tx_lclk_io;
      end
   end

   etx_io u_etx_io (
      .tx_lclk_io (tx_lclk_io),
      .nreset     (nreset),
      .tx_packet  (tx_packet),
      .tx_access  (tx_access),
      .tx_burst   (tx_burst),
      .txi_wait   (txi_wait),
      .tx_lane    (tx_lane),
      .tx_frame   (tx_frame),
      .tx_io_ack  (tx_io_ack),
      .tx_wait    (tx_wait)
   );

   etx_checker u_checker (
      .tx_lclk_io (tx_lclk_io),
      .nreset     (nreset),
      .tx_access  (tx_access),
      .tx_lane    (tx_lane),
      .tx_frame   (tx_frame),
      .tx_io_ack  (tx_io_ack),
      .txi_wait   (txi_wait),
      .tx_wait    (tx_wait),
      .lane_errs  (lane_errs),
      .frame_errs (frame_errs),
      .ack_errs   (ack_errs),
      .wait_errs  (wait_errs),
      .other_errs (other_errs)
   );

   // Ack polled on falling edges, where it is stable
   task automatic wait_for_ack(input logic level);
      int n;
      n = 0;
      while (tx_io_ack !== level && n < WAIT_LIMIT)
      begin
         @(negedge tx_lclk_io);
         n++;
      end
      if (tx_io_ack !== level)
      begin
         $display("Timeout at %0t: tx_io_ack never went to %b", $time, level);
         run_errs++;
         timed_out = 1'b1;
      end
   endtask

   // Let the last frame run out
   task automatic drain_frame();
      int n;
      n = 0;
      while (tx_frame !== 1'b0 && n < WAIT_LIMIT)
      begin
         @(negedge tx_lclk_io);
         n++;
      end
      if (tx_frame !== 1'b0)
      begin
         $display("Timeout at %0t: tx_frame stayed high after the last packet", $time);
         run_errs++;
      end
   endtask

   // ########################################################################
   // File-driven packets
   // ########################################################################

   initial
   begin
      int           fd;
      int           nb;
      int           gap;
      string        line;
      logic         w;
      logic         wr_bit;
      logic         rd_bit;
      logic [1:0]   dm;
      logic [3:0]   ctrl;
      logic [31:0]  dst;
      logic [31:0]  data;
      logic [31:0]  src;
      logic [15:0]  words [7];
      logic [127:0] junk;
      void'($urandom(32'heb31_6017));
      run_errs  = 0;
      timed_out = 1'b0;
      nreset    = 1'b0;
      tx_packet = '0;
      tx_access = 1'b0;
      tx_burst  = 1'b0;
      txi_wait  = '0;
      // Three clocks in reset, then a quiet stretch
      repeat (3) @(negedge tx_lclk_io);
      nreset = 1'b1;
      repeat (2) @(negedge tx_lclk_io);
      fd = $fopen("tb/etx_stimulus.txt", "r");
      if (fd == 0)
      begin
         $display("Could not open tb/etx_stimulus.txt");
         run_errs++;
      end
      else
      begin
         while (!timed_out && $fgets(line, fd) > 0)
         begin
            // Skip column notes and blank lines
            if (line.len() < 2 || line[0] == "#")
               continue;
            if ($sscanf(line, "%h %h %h %h %h %h %d %b %b %h %h %h %h %h %h %h",
                        w, dm, ctrl, dst, data, src, nb, wr_bit, rd_bit, words[0],
                        words[1], words[2], words[3], words[4], words[5], words[6]) != 16)
            begin
               $display("Malformed stimulus line: %s", line);
               run_errs++;
               continue;
            end
            // Header and first beat, then one data beat per burst repeat
            for (int i = 0; i < 7; i++)
               u_checker.queue_word(words[i]);
            for (int b = 0; b < nb; b++)
               for (int i = 3; i < 7; i++)
                  u_checker.queue_word(words[i]);
            u_checker.add_frame(7 + 4 * nb);
            // Packet built from the mesh field layout
            tx_packet = {src, data, dst, 1'b0, ctrl, dm, w};
            tx_access = 1'b1;
            tx_burst  = (nb > 0);
            txi_wait  = {wr_bit, rd_bit};
            @(negedge tx_lclk_io);
            tx_access = 1'b0;
            // Fresh noise on the bus, decode keeps the captured packet
            junk      = {$urandom, $urandom, $urandom, $urandom};
            tx_packet = junk[`ETX_PW-1:0];
            if (nb > 0)
            begin
               // Dropped before the CYCLE7 exit that ends the burst
               repeat (4 * nb + 4) @(negedge tx_lclk_io);
               tx_burst = 1'b0;
            end
            wait_for_ack(1'b1);
            wait_for_ack(1'b0);
            gap = 1 + ($urandom % 5);
            repeat (gap) @(negedge tx_lclk_io);
         end
         $fclose(fd);
      end
      drain_frame();
      repeat (3) @(negedge tx_lclk_io);
      if (u_checker.words_left() != 0)
      begin
         $display("%0d expected lane words never appeared", u_checker.words_left());
         run_errs++;
      end
      $display("Errors: lane %0d, frame %0d, ack %0d, wait %0d, checker %0d, run %0d",
               lane_errs, frame_errs, ack_errs, wait_errs, other_errs, run_errs);
      if (lane_errs + frame_errs + ack_errs + wait_errs + other_errs + run_errs == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule
